// ==== hw/anc_data_pkg.sv ====
package anc_data_pkg;

    localparam int TAPS        = 8;
    localparam int WEIGHT_FRAC = 12; // Weights are Q11.12.
    localparam int MU_SHIFT    = 10; // Step size of 2^-10 in the LMS update.

    localparam int SAMPLE_BITS = 14;
    localparam int SAMPLE_MAX  = 2 ** (SAMPLE_BITS - 1) - 1;
    localparam int SAMPLE_MIN  = -(2 ** (SAMPLE_BITS - 1));

    // Reference, primary, estimate and output samples.
    typedef logic signed [SAMPLE_BITS-1:0] sample_t;

    // Primary minus estimate, one bit wider than a sample so it never wraps.
    typedef logic signed [SAMPLE_BITS:0] err_t;

    typedef logic signed [23:0] weight_t; // Wraps on overflow.

    typedef logic signed [47:0] acc_t;

    typedef logic [$clog2(TAPS)-1:0] tap_idx_t;

    // Element 0 holds the newest reference sample.
    typedef sample_t tap_vec_t [TAPS];

endpackage

// ==== hw/anc_ctrl_pkg.sv ====
package anc_ctrl_pkg;

    // One frame walks through these phases in order and parks in ST_IDLE.
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FILTER,
        ST_UPDATE,
        ST_SHIFT,
        ST_HOLD
    } frame_state_t;

    // Index of the final tap of the filter and update phases.
    localparam anc_data_pkg::tap_idx_t LAST_TAP =
        anc_data_pkg::tap_idx_t'(anc_data_pkg::TAPS - 1);

endpackage

// ==== hw/frame_ctrl_if.sv ====
`timescale 1ns/1ps

interface frame_ctrl_if;
    import anc_ctrl_pkg::*;

    logic                    filter_en;
    logic                    update_en;
    logic                    shift_en;
    anc_data_pkg::tap_idx_t  tap_index;
    logic                    last_tap;

    assign last_tap = (tap_index == LAST_TAP); // Marks the closing cycle of a phase.

    modport sequencer (
        output filter_en,
        output update_en,
        output shift_en,
        output tap_index
    );

    modport channel (
        input filter_en,
        input update_en,
        input tap_index,
        input last_tap
    );

    modport line (
        input shift_en
    );

endinterface

// ==== hw/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer (
    input  logic            clk,
    input  logic            rstn,
    input  logic            head_flag,
    output logic            busy,
    frame_ctrl_if.sequencer ctrl
);
    import anc_data_pkg::*;
    import anc_ctrl_pkg::*;

    frame_state_t state;
    frame_state_t state_next;
    tap_idx_t     tap_cnt;
    tap_idx_t     tap_cnt_next;
    logic         tap_last;
    logic         tap_phase;

    assign tap_last  = (tap_cnt == LAST_TAP);
    assign tap_phase = (state == ST_FILTER) || (state == ST_UPDATE);

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
            begin
                if (head_flag)
                begin
                    state_next = ST_FILTER;
                end
            end
            ST_FILTER:
            begin
                if (tap_last)
                begin
                    state_next = ST_UPDATE;
                end
            end
            ST_UPDATE:
            begin
                if (tap_last)
                begin
                    state_next = ST_SHIFT;
                end
            end
            ST_SHIFT:
            begin
                state_next = ST_HOLD;
            end
            ST_HOLD:
            begin
                if (!head_flag)
                begin
                    state_next = ST_IDLE; // Wait for head_flag to fall before rearming.
                end
            end
            default:
            begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // The counter restarts at zero whenever a tap phase begins.
    always_comb
    begin
        if (tap_phase && !tap_last)
        begin
            tap_cnt_next = tap_cnt + tap_idx_t'(1);
        end
        else
        begin
            tap_cnt_next = '0;
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state   <= ST_IDLE;
            tap_cnt <= '0;
            busy    <= 1'b0;
        end
        else
        begin
            state   <= state_next;
            tap_cnt <= tap_cnt_next;
            busy    <= (state_next != ST_IDLE);
        end
    end

    assign ctrl.filter_en = (state == ST_FILTER);
    assign ctrl.update_en = (state == ST_UPDATE);
    assign ctrl.shift_en  = (state == ST_SHIFT); // Single cycle, so a pulse.
    assign ctrl.tap_index = tap_cnt;

endmodule

// ==== hw/sample_line.sv ====
`timescale 1ns/1ps

module sample_line (
    input  logic                   clk,
    input  logic                   rstn,
    input  anc_data_pkg::sample_t  reff,
    input  anc_data_pkg::sample_t  buffer_2,
    input  anc_data_pkg::sample_t  buffer_3,
    frame_ctrl_if.line             ctrl,
    output anc_data_pkg::tap_vec_t ref_taps,
    output anc_data_pkg::sample_t  prim_2,
    output anc_data_pkg::sample_t  prim_3
);
    import anc_data_pkg::*;

    tap_vec_t taps;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < TAPS; i++)
            begin
                taps[i] <= '0;
            end
            prim_2 <= '0;
            prim_3 <= '0;
        end
        else if (ctrl.shift_en)
        begin
            taps[0] <= reff; // Newest sample enters at tap 0.
            for (int i = 1; i < TAPS; i++)
            begin
                taps[i] <= taps[i-1];
            end
            prim_2 <= buffer_2;
            prim_3 <= buffer_3;
        end
    end

    always_comb
    begin
        for (int i = 0; i < TAPS; i++)
        begin
            ref_taps[i] = taps[i];
        end
    end

endmodule

// ==== hw/lms_channel.sv ====
`timescale 1ns/1ps

module lms_channel (
    input  logic                   clk,
    input  logic                   rstn,
    frame_ctrl_if.channel          ctrl,
    input  anc_data_pkg::tap_vec_t ref_taps,
    input  anc_data_pkg::sample_t  prim,
    output anc_data_pkg::sample_t  y
);
    import anc_data_pkg::*;

    weight_t weights [TAPS];
    acc_t    acc;
    sample_t ref_sel;
    weight_t w_sel;
    acc_t    mac_prod;
    acc_t    mac_base;
    acc_t    mac_sum;
    acc_t    y_full;
    sample_t y_sat;
    err_t    err;
    acc_t    upd_prod;
    weight_t upd_step;

    // Both phases walk the same tap index, so one read port serves the MAC and the update.
    assign ref_sel = ref_taps[ctrl.tap_index];
    assign w_sel   = weights[ctrl.tap_index];

    assign mac_prod = acc_t'(w_sel) * acc_t'(ref_sel);

    always_comb
    begin
        if (ctrl.tap_index == '0)
        begin
            mac_base = '0; // A new frame starts a fresh sum.
        end
        else
        begin
            mac_base = acc;
        end
    end

    assign mac_sum = mac_base + mac_prod;
    assign y_full  = mac_sum >>> WEIGHT_FRAC;

    always_comb
    begin
        if (y_full > acc_t'(SAMPLE_MAX))
        begin
            y_sat = sample_t'(SAMPLE_MAX);
        end
        else if (y_full < acc_t'(SAMPLE_MIN))
        begin
            y_sat = sample_t'(SAMPLE_MIN);
        end
        else
        begin
            y_sat = sample_t'(y_full);
        end
    end

    // Error is taken against the estimate held since the end of the filter phase.
    assign err = err_t'(prim) - err_t'(y);

    assign upd_prod = acc_t'(err) * acc_t'(ref_sel);
    assign upd_step = weight_t'(upd_prod >>> MU_SHIFT);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < TAPS; i++)
            begin
                weights[i] <= '0;
            end
            acc <= '0;
            y   <= '0;
        end
        else
        begin
            if (ctrl.filter_en)
            begin
                acc <= mac_sum;
                if (ctrl.last_tap)
                begin
                    y <= y_sat; // Includes the product of the final tap.
                end
            end
            if (ctrl.update_en)
            begin
                weights[ctrl.tap_index] <= w_sel + upd_step; // Wraps at 24 bits.
            end
        end
    end

endmodule

// ==== hw/output_mixer.sv ====
`timescale 1ns/1ps

module output_mixer (
    input  logic                  clk,
    input  logic                  rstn,
    input  anc_data_pkg::sample_t y_2,
    input  anc_data_pkg::sample_t y_3,
    output anc_data_pkg::sample_t dout
);
    import anc_data_pkg::*;

    err_t    sum;
    sample_t sum_sat;

    assign sum = err_t'(y_2) + err_t'(y_3); // One extra bit holds any pair of samples.

    always_comb
    begin
        if (sum > err_t'(SAMPLE_MAX))
        begin
            sum_sat = sample_t'(SAMPLE_MAX);
        end
        else if (sum < err_t'(SAMPLE_MIN))
        begin
            sum_sat = sample_t'(SAMPLE_MIN);
        end
        else
        begin
            sum_sat = sample_t'(sum);
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            dout <= '0;
        end
        else
        begin
            dout <= sum_sat;
        end
    end

endmodule

// ==== hw/anc_top.sv ====
`timescale 1ns/1ps

module anc_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  head_flag,
    input  anc_data_pkg::sample_t buffer_2,
    input  anc_data_pkg::sample_t buffer_3,
    input  anc_data_pkg::sample_t reff,
    output anc_data_pkg::sample_t dout,
    output logic                  busy
);
    import anc_data_pkg::*;

    tap_vec_t ref_taps;
    sample_t  prim_2;
    sample_t  prim_3;
    sample_t  y_2;
    sample_t  y_3;

    frame_ctrl_if ctrl ();

    frame_sequencer u_sequencer (
        .clk       (clk),
        .rstn      (rstn),
        .head_flag (head_flag),
        .busy      (busy),
        .ctrl      (ctrl.sequencer)
    );

    // The reference line is shared, each channel gets its own primary.
    sample_line u_sample_line (
        .clk      (clk),
        .rstn     (rstn),
        .reff     (reff),
        .buffer_2 (buffer_2),
        .buffer_3 (buffer_3),
        .ctrl     (ctrl.line),
        .ref_taps (ref_taps),
        .prim_2   (prim_2),
        .prim_3   (prim_3)
    );

    lms_channel u_channel_2 (
        .clk      (clk),
        .rstn     (rstn),
        .ctrl     (ctrl.channel),
        .ref_taps (ref_taps),
        .prim     (prim_2),
        .y        (y_2)
    );

    lms_channel u_channel_3 (
        .clk      (clk),
        .rstn     (rstn),
        .ctrl     (ctrl.channel),
        .ref_taps (ref_taps),
        .prim     (prim_3),
        .y        (y_3)
    );

    output_mixer u_output_mixer (
        .clk  (clk),
        .rstn (rstn),
        .y_2  (y_2),
        .y_3  (y_3),
        .dout (dout)
    );

endmodule

// ==== test/anc_assertions.sv ====
`timescale 1ns/1ps

module anc_assertions (
    input logic                   clk,
    input logic                   rstn,
    input logic                   busy,
    input logic                   filter_en,
    input logic                   update_en,
    input logic                   shift_en,
    input anc_data_pkg::tap_idx_t tap_index
);
    import anc_data_pkg::*;
    import anc_ctrl_pkg::*;

    int failures = 0;

    tap_count: assert property (@(posedge clk) disable iff (!rstn)
        (filter_en || update_en) && (tap_index != LAST_TAP)
        |=> (filter_en || update_en) && (tap_index == $past(tap_index) + tap_idx_t'(1)))
    else
    begin
        failures++;
        $error("tap_index did not step by one within a tap phase");
    end

    // The filter phase hands over to the update phase with a fresh tap count.
    phase_handover: assert property (@(posedge clk) disable iff (!rstn)
        filter_en && (tap_index == LAST_TAP) |=> update_en && !filter_en && (tap_index == '0))
    else
    begin
        failures++;
        $error("filter phase not followed by a single update phase from tap zero");
    end

    shift_pulse: assert property (@(posedge clk) disable iff (!rstn) shift_en |=> !shift_en)
    else
    begin
        failures++;
        $error("shift_en longer than one cycle");
    end

    // Shift must come straight after the final update cycle.
    shift_order: assert property (@(posedge clk) disable iff (!rstn)
        $rose(shift_en) |-> $past(update_en) && ($past(tap_index) == LAST_TAP))
    else
    begin
        failures++;
        $error("shift_en without a completed update phase");
    end

    busy_reset: assert property (@(posedge clk) !rstn |-> !busy)
    else
    begin
        failures++;
        $error("busy high during reset");
    end

endmodule

bind frame_sequencer anc_assertions u_anc_assertions (
    .clk       (clk),
    .rstn      (rstn),
    .busy      (busy),
    .filter_en (ctrl.filter_en),
    .update_en (ctrl.update_en),
    .shift_en  (ctrl.shift_en),
    .tap_index (ctrl.tap_index)
);

// ==== test/tb_anc_top.sv ====
`timescale 1ns/1ps

module tb_anc_top;
    import anc_data_pkg::*;

    logic    clk;
    logic    rstn;
    logic    head_flag;
    sample_t buffer_2;
    sample_t buffer_3;
    sample_t reff;
    sample_t dout;
    logic    busy;

    weight_t m_w [2][TAPS];
    sample_t m_taps [TAPS];
    sample_t m_prim [2];
    int      checks;
    int      errors;
    int      test_errors;
    int      tests_run;
    int      tests_failed;

    anc_top u_anc_top (.*);

    always #4 clk = ~clk;

    function automatic sample_t clamp(input longint v);
        return (v > longint'(SAMPLE_MAX)) ? sample_t'(SAMPLE_MAX) :
               (v < longint'(SAMPLE_MIN)) ? sample_t'(SAMPLE_MIN) : sample_t'(v);
    endfunction

    function automatic sample_t rand_sample(input int span);
        return sample_t'(int'($urandom % (2 * span + 1)) - span);
    endfunction

    function automatic sample_t rand_extreme();
        return (($urandom & 1) != 0) ? sample_t'(SAMPLE_MAX) : sample_t'(SAMPLE_MIN);
    endfunction

    // Filter then LMS update of one channel, returns the new estimate.
    function automatic sample_t model_channel(input int ch);
        longint  acc;
        sample_t y;
        acc = 0;
        for (int k = 0; k < TAPS; k++)
        begin
            acc += longint'(m_w[ch][k]) * longint'(m_taps[k]);
        end
        y = clamp(acc >>> WEIGHT_FRAC);
        for (int k = 0; k < TAPS; k++)
        begin
            m_w[ch][k] = weight_t'(longint'(m_w[ch][k]) +
                ((longint'(m_prim[ch]) - longint'(y)) * longint'(m_taps[k]) >>> MU_SHIFT));
        end
        return y;
    endfunction

    task automatic model_shift(input sample_t r, input sample_t b2, input sample_t b3);
        for (int k = TAPS - 1; k > 0; k--)
        begin
            m_taps[k] = m_taps[k-1];
        end
        m_taps[0] = r;
        m_prim[0] = b2;
        m_prim[1] = b3;
    endtask

    task automatic check_sample(input sample_t got, input sample_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic wait_idle(output int edges);
        edges = 0;
        while (busy && edges < 40)
        begin
            step_cycle();
            edges++;
        end
        if (busy)
        begin
            $display("Timeout: busy still high after %0d cycles at %0t ns", edges, $time);
            test_errors++;
        end
    endtask

    // One frame from head_flag to idle. In junk mode the inputs only carry the frame
    // values on the shift edge.
    task automatic run_frame(input sample_t r, input sample_t b2, input sample_t b3,
                             input bit junk, input bit drop_early, input int hold);
        sample_t exp_dout;
        int      edges;
        exp_dout = clamp(longint'(model_channel(0)) + longint'(model_channel(1)));
        head_flag = 1'b1;
        for (int n = 0; n <= 2 * TAPS + 1; n++)
        begin
            reff     = (junk && n != 2 * TAPS + 1) ? rand_sample(SAMPLE_MAX) : r;
            buffer_2 = (junk && n != 2 * TAPS + 1) ? rand_sample(SAMPLE_MAX) : b2;
            buffer_3 = (junk && n != 2 * TAPS + 1) ? rand_sample(SAMPLE_MAX) : b3;
            step_cycle();
            check_level(busy, 1'b1, "busy during frame");
            if (n == TAPS + 2)
            begin
                check_sample(dout, exp_dout, "dout of frame");
            end
            if (drop_early && n == 2)
            begin
                head_flag = 1'b0; // Falls inside the filter phase.
            end
        end
        model_shift(r, b2, b3);
        for (int i = 0; i < hold; i++)
        begin
            step_cycle();
            check_level(busy, 1'b1, "busy while head_flag held");
        end
        head_flag = 1'b0;
        wait_idle(edges);
        check_level(edges == 1, 1'b1, "busy falls one edge after head_flag low");
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0)
        begin
            $display("Test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s: %0d mismatches", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial
    begin
        sample_t r;
        sample_t b2;
        sample_t b3;
        void'($urandom(5259));
        clk = 1'b0;
        rstn = 1'b0;
        head_flag = 1'b0;
        reff = '0;
        buffer_2 = '0;
        buffer_3 = '0;
        checks = 0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int k = 0; k < TAPS; k++)
        begin
            m_taps[k] = '0;
            m_w[0][k] = '0;
            m_w[1][k] = '0;
        end
        m_prim[0] = '0;
        m_prim[1] = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        check_level(busy, 1'b0, "busy after reset");
        check_sample(dout, sample_t'(0), "dout after reset");
        repeat (10)
        begin
            step_cycle();
            check_level(busy, 1'b0, "busy with head_flag low");
        end
        finish_test("reset");

        run_frame(rand_sample(4000), rand_sample(4000), rand_sample(4000), 1'b0, 1'b0, 0);
        finish_test("first_frame");

        for (int f = 0; f < 200; f++)
        begin
            r  = rand_sample(4000);
            b2 = (f % 2 == 0) ? sample_t'(int'(r) / 2 + int'(rand_sample(100))) : rand_sample(4000);
            b3 = (f % 2 == 0) ? sample_t'(-int'(r) / 4 + int'(rand_sample(100))) : rand_sample(4000);
            run_frame(r, b2, b3, 1'b0, 1'b0, 0);
        end
        finish_test("random_frames");

        for (int f = 0; f < 12; f++)
        begin
            run_frame(rand_extreme(), rand_extreme(), rand_extreme(), 1'b0, 1'b0, 0);
        end
        finish_test("full_scale");

        run_frame(rand_sample(4000), rand_sample(4000), rand_sample(4000), 1'b0, 1'b1, 0);
        run_frame(rand_sample(4000), rand_sample(4000), rand_sample(4000), 1'b0, 1'b0, 6);
        finish_test("head_flag");

        for (int f = 0; f < 20; f++)
        begin
            run_frame(rand_sample(4000), rand_sample(4000), rand_sample(4000), 1'b1, 1'b0, 0);
        end
        finish_test("input_timing");

        errors += u_anc_top.u_sequencer.u_anc_assertions.failures;
        $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/anc_data_pkg.sv
hw/anc_ctrl_pkg.sv
hw/frame_ctrl_if.sv
hw/frame_sequencer.sv
hw/sample_line.sv
hw/lms_channel.sv
hw/output_mixer.sv
hw/anc_top.sv
test/anc_assertions.sv
test/tb_anc_top.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_anc_top -f verilog.f -o tb_anc_top
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_anc_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
echo "Simulation reported failures"
exit 1
